// ==== accumulatorCpu.f ====
source/cpuPkg.sv
source/alu.sv
source/programCounter.sv
source/mainMemory.sv
source/executeUnit.sv
source/controlFsm.sv
source/hostBus.sv
source/accumulatorCpu.sv
bench/clockGen.sv
bench/accumulatorCpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module accumulatorCpuTb -f accumulatorCpu.f

output=$(./obj_dir/VaccumulatorCpuTb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1

// ==== bench/accumulatorCpuTb.sv ====
`timescale 1ns/1ns

module accumulatorCpuTb
    import cpuPkg::*;
();

    // table sizes and run limits
    localparam int fixedRows      = 16;
    localparam int randomRows     = 16;
    localparam int totalRows      = fixedRows + randomRows;
    localparam int timeoutCycles  = totalRows * 200 + 2000;
    localparam int handshakeLimit = 20;
    localparam int pollLimit      = 100;
    localparam int tripCount      = 8;

    logic        clk;
    logic        arstN;
    logic [31:0] awAddr;
    logic        awValid;
    logic        awReady;
    logic [31:0] wData;
    logic        wValid;
    logic        wReady;
    logic [1:0]  bResp;
    logic        bValid;
    logic        bReady;
    logic [31:0] arAddr;
    logic        arValid;
    logic        arReady;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic        rValid;
    logic        rReady;

    // stimulus table with one row per ALU program
    instrOp      tabOp  [totalRows];
    logic [15:0] tabA   [totalRows];
    logic [15:0] tabB   [totalRows];
    logic [15:0] tabExp [totalRows];
    // program image for the current test
    logic [15:0] progWords [16];
    int          progLen;
    logic [31:0] lfsrState;
    int          checkCount;
    int          valueErrors;
    int          otherErrors;
    int          cycleCount;

    clockGen #(
        .period      (10),
        .resetCycles (5)
    ) clockGen_inst (
        .clk   (clk),
        .arstN (arstN)
    );

    accumulatorCpu #(
        .memWords (4096)
    ) accumulatorCpu_inst (
        .clk     (clk),
        .arstN   (arstN),
        .awAddr  (awAddr),
        .awValid (awValid),
        .awReady (awReady),
        .wData   (wData),
        .wValid  (wValid),
        .wReady  (wReady),
        .bResp   (bResp),
        .bValid  (bValid),
        .bReady  (bReady),
        .arAddr  (arAddr),
        .arValid (arValid),
        .arReady (arReady),
        .rData   (rData),
        .rResp   (rResp),
        .rValid  (rValid),
        .rReady  (rReady)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    task automatic takeBits(input int count, output logic [15:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
    endtask

    // expected ALU result for accumulator a and memory operand b
    function automatic logic [15:0] refAlu(input instrOp opc, input logic [15:0] a,
                                           input logic [15:0] b);
        logic [31:0] product;
        product = {16'h0000, a} * {16'h0000, b};
        case (opc)
            opAdd:   return a + b;
            opSub:   return a - b;
            opMul:   return product[15:0];
            opDiv: begin
                if (b == 16'h0000) begin
                    return 16'hffff;
                end
                return a / b;
            end
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opShl:   return {a[14:0], 1'b0};
            opShr:   return {1'b0, a[15:1]};
            opRol:   return {a[14:0], a[15]};
            opCmpEq: return (a == b) ? 16'd1 : 16'd0;
            // load passes the operand
            default: return b;
        endcase
    endfunction

    function automatic logic [15:0] encodeInstr(input instrOp opc, input logic [11:0] addr);
        return {opc, addr};
    endfunction

    // window base at bit 14 with the word address in bits 13:2
    function automatic logic [31:0] windowAddr(input logic [11:0] word);
        return 32'h0000_4000 | {18'd0, word, 2'b00};
    endfunction

    task automatic setRow(input int row, input instrOp opc, input logic [15:0] a,
                          input logic [15:0] b, input logic [15:0] expected);
        tabOp[row]  = opc;
        tabA[row]   = a;
        tabB[row]   = b;
        tabExp[row] = expected;
    endtask

    task automatic fillTable;
        int          row;
        int          opIdx;
        logic [15:0] bits;
        logic [15:0] a;
        logic [15:0] b;
        // hand-worked corner cases
        setRow(0, opLoad, 16'h1111, 16'h2222, 16'h2222);
        setRow(1, opAdd, 16'h1234, 16'h0101, 16'h1335);
        setRow(2, opAdd, 16'hffff, 16'h0002, 16'h0001);
        setRow(3, opSub, 16'h0005, 16'h0007, 16'hfffe);
        setRow(4, opMul, 16'h0123, 16'h0010, 16'h1230);
        setRow(5, opMul, 16'h8000, 16'h0003, 16'h8000);
        setRow(6, opDiv, 16'h0064, 16'h0007, 16'h000e);
        setRow(7, opDiv, 16'h1234, 16'h0000, 16'hffff);
        setRow(8, opAnd, 16'hf0f0, 16'h3c3c, 16'h3030);
        setRow(9, opOr, 16'hf0f0, 16'h0f01, 16'hfff1);
        setRow(10, opXor, 16'haaaa, 16'hffff, 16'h5555);
        setRow(11, opShl, 16'h8001, 16'h0000, 16'h0002);
        setRow(12, opShr, 16'h8001, 16'h0000, 16'h4000);
        setRow(13, opRol, 16'h8001, 16'h1234, 16'h0003);
        setRow(14, opCmpEq, 16'h4321, 16'h4321, 16'h0001);
        setRow(15, opCmpEq, 16'h4321, 16'h4320, 16'h0000);
        // random ALU ops from opAdd up to opCmpEq
        for (row = fixedRows; row < totalRows; row++) begin
            takeBits(4, bits);
            opIdx = int'(bits[3:0]) % 11;
            takeBits(16, a);
            takeBits(16, b);
            setRow(row, instrOp'(4'(opIdx + int'(opAdd))), a, b, 16'h0000);
            tabExp[row] = refAlu(tabOp[row], a, b);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        assert (got == expected) else begin
            valueErrors++;
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic checkResp(input string name, input logic [1:0] got,
                             input logic [1:0] expected);
        checkCount++;
        assert (got == expected) else begin
            valueErrors++;
            $display("[ERROR] time %0t: %s is %b, expected %b", $time, name, got, expected);
        end
    endtask

    // valid held until the ready pulse and response taken on bValid
    task automatic axiWrite(input logic [31:0] addr, input logic [15:0] data,
                            output logic [1:0] resp);
        int waitCount;
        waitCount = 0;
        awAddr    = addr;
        wData     = {16'h0000, data};
        awValid   = 1'b1;
        wValid    = 1'b1;
        bReady    = 1'b1;
        @(posedge clk);
        #1;
        while (!(awReady && wReady) && waitCount < handshakeLimit) begin
            @(posedge clk);
            #1;
            waitCount++;
        end
        // address and data accepted on this edge
        @(posedge clk);
        #1;
        awValid = 1'b0;
        wValid  = 1'b0;
        while (!bValid && waitCount < handshakeLimit) begin
            @(posedge clk);
            #1;
            waitCount++;
        end
        resp = bResp;
        assert (waitCount < handshakeLimit) else begin
            otherErrors++;
            $display("write to %h got no handshake from the DUT", addr);
        end
        @(posedge clk);
        #1;
        bReady = 1'b0;
    endtask

    task automatic axiRead(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int waitCount;
        waitCount = 0;
        arAddr    = addr;
        arValid   = 1'b1;
        rReady    = 1'b1;
        @(posedge clk);
        #1;
        while (!arReady && waitCount < handshakeLimit) begin
            @(posedge clk);
            #1;
            waitCount++;
        end
        @(posedge clk);
        #1;
        arValid = 1'b0;
        // one extra cycle for memory reads
        while (!rValid && waitCount < handshakeLimit) begin
            @(posedge clk);
            #1;
            waitCount++;
        end
        data = rData;
        resp = rResp;
        assert (waitCount < handshakeLimit) else begin
            otherErrors++;
            $display("read from %h got no handshake from the DUT", addr);
        end
        @(posedge clk);
        #1;
        rReady = 1'b0;
    endtask

    task automatic writeMem(input logic [11:0] word, input logic [15:0] data);
        logic [1:0] resp;
        axiWrite(windowAddr(word), data, resp);
        checkResp("bResp", resp, axiOkay);
    endtask

    task automatic readMem(input logic [11:0] word, output logic [15:0] data);
        logic [31:0] value;
        logic [1:0]  resp;
        axiRead(windowAddr(word), value, resp);
        checkResp("rResp", resp, axiOkay);
        data = value[15:0];
    endtask

    task automatic checkMem(input logic [11:0] word, input logic [15:0] expected);
        logic [15:0] data;
        readMem(word, data);
        checkValue($sformatf("mem[%0d]", word), {16'h0000, data}, {16'h0000, expected});
    endtask

    task automatic checkRegister(input logic [31:0] addr, input string name,
                                 input logic [31:0] expected);
        logic [31:0] value;
        logic [1:0]  resp;
        axiRead(addr, value, resp);
        checkResp("rResp", resp, axiOkay);
        checkValue(name, value, expected);
    endtask

    task automatic writeProgram;
        int k;
        for (k = 0; k < progLen; k++) begin
            writeMem(12'(k), progWords[k]);
        end
    endtask

    task automatic startCpu;
        logic [1:0] resp;
        axiWrite(32'h0000_0000, 16'h0001, resp);
        checkResp("bResp", resp, axiOkay);
    endtask

    // poll status bit 1
    task automatic waitHalted;
        logic [31:0] status;
        logic [1:0]  resp;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < pollLimit) begin
            axiRead(32'h0000_0000, status, resp);
            polls++;
        end
        assert (status[1]) else begin
            otherErrors++;
            $display("CPU still not halted after %0d status polls", polls);
        end
    endtask

    // load 100, op 101, store 102, halt
    task automatic applyRow(input int row);
        progWords[0] = encodeInstr(opLoad, 12'd100);
        progWords[1] = encodeInstr(tabOp[row], 12'd101);
        progWords[2] = encodeInstr(opStore, 12'd102);
        progWords[3] = encodeInstr(opHalt, 12'd0);
        progLen      = 4;
        writeProgram();
        writeMem(12'd100, tabA[row]);
        writeMem(12'd101, tabB[row]);
        startCpu();
        waitHalted();
        checkRegister(32'h0000_0004, $sformatf("acc (row %0d, op %0d)", row, tabOp[row]),
                      {16'h0000, tabExp[row]});
        checkMem(12'd102, tabExp[row]);
    endtask

    // jump skips the store to 110
    task automatic jumpOver;
        writeMem(12'd100, 16'h0005);
        writeMem(12'd110, 16'hffff);
        writeMem(12'd111, 16'hffff);
        progWords[0] = encodeInstr(opLoad, 12'd100);
        progWords[1] = encodeInstr(opJump, 12'd3);
        progWords[2] = encodeInstr(opStore, 12'd110);
        progWords[3] = encodeInstr(opStore, 12'd111);
        progWords[4] = encodeInstr(opHalt, 12'd0);
        progLen      = 5;
        writeProgram();
        startCpu();
        waitHalted();
        checkMem(12'd110, 16'hffff);
        checkMem(12'd111, 16'h0005);
    endtask

    // taken branch stores to 111 and fall-through to 110
    task automatic jumpIfZero(input logic [15:0] value);
        writeMem(12'd100, value);
        writeMem(12'd110, 16'hffff);
        writeMem(12'd111, 16'hffff);
        progWords[0] = encodeInstr(opLoad, 12'd100);
        progWords[1] = encodeInstr(opJumpZero, 12'd4);
        progWords[2] = encodeInstr(opStore, 12'd110);
        progWords[3] = encodeInstr(opHalt, 12'd0);
        progWords[4] = encodeInstr(opStore, 12'd111);
        progWords[5] = encodeInstr(opHalt, 12'd0);
        progLen      = 6;
        writeProgram();
        startCpu();
        waitHalted();
        if (value == 16'h0000) begin
            checkMem(12'd110, 16'hffff);
            checkMem(12'd111, 16'h0000);
        end else begin
            checkMem(12'd110, value);
            checkMem(12'd111, 16'hffff);
        end
    endtask

    // window accesses during a long run must bounce
    task automatic busyAccess;
        logic [31:0] value;
        logic [1:0]  resp;
        int          k;
        writeMem(12'd120, 16'h1234);
        writeMem(12'd100, 16'h0003);
        progWords[0] = encodeInstr(opLoad, 12'd100);
        for (k = 1; k <= 10; k++) begin
            progWords[k] = encodeInstr(opAdd, 12'd100);
        end
        progWords[11] = encodeInstr(opHalt, 12'd0);
        progLen       = 12;
        writeProgram();
        startCpu();
        // running and not yet halted
        checkRegister(32'h0000_0000, "status", 32'h1);
        axiWrite(windowAddr(12'd120), 16'hbeef, resp);
        checkResp("bResp", resp, axiSlvErr);
        axiRead(windowAddr(12'd120), value, resp);
        checkResp("rResp", resp, axiSlvErr);
        waitHalted();
        checkMem(12'd120, 16'h1234);
        checkRegister(32'h0000_0004, "acc", 32'd33);
        checkRegister(32'h0000_0000, "status", 32'h2);
    endtask

    task automatic roundTrips;
        logic [15:0] bits;
        logic [15:0] data;
        int          k;
        for (k = 0; k < tripCount; k++) begin
            takeBits(12, bits);
            takeBits(16, data);
            writeMem(bits[11:0], data);
            checkMem(bits[11:0], data);
        end
    endtask

    initial begin
        int row;
        awAddr      = '0;
        awValid     = 1'b0;
        wData       = '0;
        wValid      = 1'b0;
        bReady      = 1'b0;
        arAddr      = '0;
        arValid     = 1'b0;
        rReady      = 1'b0;
        progLen     = 0;
        checkCount  = 0;
        valueErrors = 0;
        otherErrors = 0;
        lfsrState   = 32'h9c51;
        fillTable();
        wait (arstN === 1'b1);
        @(posedge clk);
        #1;
        // idle machine with a cleared accumulator
        checkRegister(32'h0000_0000, "status", 32'h0);
        checkRegister(32'h0000_0004, "acc", 32'h0);
        for (row = 0; row < totalRows; row++) begin
            applyRow(row);
        end
        jumpOver();
        jumpIfZero(16'h0000);
        jumpIfZero(16'h0007);
        busyAccess();
        roundTrips();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped after %0d cycles before the tests finished", cycleCount);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== bench/clockGen.sv ====
`timescale 1ns/1ns

module clockGen #(
    parameter int period      = 10,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic arstN
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset released just after an edge, like the other inputs
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
    end

endmodule

// ==== source/accumulatorCpu.sv ====
`timescale 1ns/1ns

module accumulatorCpu
    import cpuPkg::*;
#(
    parameter int memWords = 4096
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic [31:0] awAddr,
    input  logic        awValid,
    output logic        awReady,
    input  logic [31:0] wData,
    input  logic        wValid,
    output logic        wReady,
    output logic [1:0]  bResp,
    output logic        bValid,
    input  logic        bReady,
    input  logic [31:0] arAddr,
    input  logic        arValid,
    output logic        arReady,
    output logic [31:0] rData,
    output logic [1:0]  rResp,
    output logic        rValid,
    input  logic        rReady
);

    // datapath
    logic [dataWidth-1:0] acc;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] memRData;
    logic                 zero;
    instrOp               op;
    // program counter control
    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] jumpAddr;
    logic                 pcClear;
    logic                 pcInc;
    logic                 pcLoad;
    // CPU memory port and accumulator control
    logic                 cpuEn;
    logic                 cpuWe;
    logic [addrWidth-1:0] cpuAddr;
    logic                 accWe;
    logic                 accFromMem;
    // host side
    logic                 running;
    logic                 halted;
    logic                 start;
    logic                 hostEn;
    logic                 hostWe;
    logic [addrWidth-1:0] hostAddr;
    logic [dataWidth-1:0] hostWData;

    alu alu_inst (
        .op     (op),
        .a      (acc),
        .b      (memRData),
        .result (aluResult)
    );

    programCounter programCounter_inst (
        .clk      (clk),
        .arstN    (arstN),
        .pcClear  (pcClear),
        .pcInc    (pcInc),
        .pcLoad   (pcLoad),
        .jumpAddr (jumpAddr),
        .pc       (pc)
    );

    // store writes the accumulator
    mainMemory #(
        .memWords (memWords)
    ) mainMemory_inst (
        .clk       (clk),
        .cpuEn     (cpuEn),
        .cpuWe     (cpuWe),
        .cpuAddr   (cpuAddr),
        .cpuWData  (acc),
        .hostEn    (hostEn),
        .hostWe    (hostWe),
        .hostAddr  (hostAddr),
        .hostWData (hostWData),
        .rData     (memRData)
    );

    executeUnit executeUnit_inst (
        .clk        (clk),
        .arstN      (arstN),
        .accWe      (accWe),
        .aluResult  (aluResult),
        .memData    (memRData),
        .accFromMem (accFromMem),
        .acc        (acc),
        .zero       (zero)
    );

    controlFsm controlFsm_inst (
        .clk        (clk),
        .arstN      (arstN),
        .start      (start),
        .memRData   (memRData),
        .zero       (zero),
        .pc         (pc),
        .cpuEn      (cpuEn),
        .cpuWe      (cpuWe),
        .cpuAddr    (cpuAddr),
        .pcClear    (pcClear),
        .pcInc      (pcInc),
        .pcLoad     (pcLoad),
        .jumpAddr   (jumpAddr),
        .op         (op),
        .accWe      (accWe),
        .accFromMem (accFromMem),
        .running    (running),
        .halted     (halted)
    );

    hostBus hostBus_inst (
        .clk       (clk),
        .arstN     (arstN),
        .awAddr    (awAddr),
        .awValid   (awValid),
        .awReady   (awReady),
        .wData     (wData),
        .wValid    (wValid),
        .wReady    (wReady),
        .bResp     (bResp),
        .bValid    (bValid),
        .bReady    (bReady),
        .arAddr    (arAddr),
        .arValid   (arValid),
        .arReady   (arReady),
        .rData     (rData),
        .rResp     (rResp),
        .rValid    (rValid),
        .rReady    (rReady),
        .running   (running),
        .halted    (halted),
        .acc       (acc),
        .memRData  (memRData),
        .start     (start),
        .hostEn    (hostEn),
        .hostWe    (hostWe),
        .hostAddr  (hostAddr),
        .hostWData (hostWData)
    );

endmodule

// ==== source/hostBus.sv ====
`timescale 1ns/1ns

module hostBus
    import cpuPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [31:0]          awAddr,
    input  logic                 awValid,
    output logic                 awReady,
    input  logic [31:0]          wData,
    input  logic                 wValid,
    output logic                 wReady,
    output logic [1:0]           bResp,
    output logic                 bValid,
    input  logic                 bReady,
    input  logic [31:0]          arAddr,
    input  logic                 arValid,
    output logic                 arReady,
    output logic [31:0]          rData,
    output logic [1:0]           rResp,
    output logic                 rValid,
    input  logic                 rReady,
    input  logic                 running,
    input  logic                 halted,
    input  logic [dataWidth-1:0] acc,
    input  logic [dataWidth-1:0] memRData,
    output logic                 start,
    output logic                 hostEn,
    output logic                 hostWe,
    output logic [addrWidth-1:0] hostAddr,
    output logic [dataWidth-1:0] hostWData
);

    logic wrAccept;
    logic rdAccept;
    logic wrFire;
    logic rdFire;
    logic wrMem;
    logic rdMem;
    logic memRdPend;

    // ready pulses, write side first so the memory port never sees both
    assign wrAccept = awValid && wValid && !awReady && !bValid;
    assign rdAccept = arValid && !arReady && !rValid && !memRdPend && !wrAccept && !awReady;
    assign wrFire   = awReady && awValid && wValid;
    assign rdFire   = arReady && arValid;

    // bit 14 selects the memory window, blocked while the CPU runs
    assign wrMem = wrFire && awAddr[14] && !running;
    assign rdMem = rdFire && arAddr[14] && !running;

    assign hostEn    = wrMem || rdMem;
    assign hostWe    = wrMem;
    assign hostAddr  = wrMem ? awAddr[13:2] : arAddr[13:2];
    assign hostWData = wData[dataWidth-1:0];

    // control register write with bit 0 set
    assign start = wrFire && !awAddr[14] && awAddr[13:2] == '0 && wData[0];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            awReady   <= 1'b0;
            wReady    <= 1'b0;
            bValid    <= 1'b0;
            arReady   <= 1'b0;
            rValid    <= 1'b0;
            memRdPend <= 1'b0;
        end else begin
            awReady <= wrAccept;
            wReady  <= wrAccept;
            arReady <= rdAccept;
            // write response one cycle after the handshake
            if (wrFire) begin
                bValid <= 1'b1;
            end else if (bReady) begin
                bValid <= 1'b0;
            end
            // memory reads finish one cycle later than registers
            memRdPend <= rdMem;
            if ((rdFire && !rdMem) || memRdPend) begin
                rValid <= 1'b1;
            end else if (rReady) begin
                rValid <= 1'b0;
            end
        end
    end

    // response payloads
    always_ff @(posedge clk) begin
        if (wrFire) begin
            bResp <= (awAddr[14] && running) ? axiSlvErr : axiOkay;
        end
        if (memRdPend) begin
            rData <= {{(32 - dataWidth){1'b0}}, memRData};
            rResp <= axiOkay;
        end else if (rdFire && !rdMem) begin
            rResp <= axiOkay;
            if (arAddr[14]) begin
                // window read while running
                rData <= '0;
                rResp <= axiSlvErr;
            end else if (arAddr[13:2] == 12'd0) begin
                rData <= {30'd0, halted, running};
            end else if (arAddr[13:2] == 12'd1) begin
                rData <= {{(32 - dataWidth){1'b0}}, acc};
            end else begin
                // unmapped reads as zero
                rData <= '0;
            end
        end
    end

endmodule

// ==== source/controlFsm.sv ====
`timescale 1ns/1ns

module controlFsm
    import cpuPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 start,
    input  logic [dataWidth-1:0] memRData,
    input  logic                 zero,
    input  logic [addrWidth-1:0] pc,
    output logic                 cpuEn,
    output logic                 cpuWe,
    output logic [addrWidth-1:0] cpuAddr,
    output logic                 pcClear,
    output logic                 pcInc,
    output logic                 pcLoad,
    output logic [addrWidth-1:0] jumpAddr,
    output instrOp               op,
    output logic                 accWe,
    output logic                 accFromMem,
    output logic                 running,
    output logic                 halted
);

    cpuState              state;
    cpuState              nextState;
    logic [dataWidth-1:0] ir;
    instrOp               irOp;
    logic [addrWidth-1:0] irAddr;

    // instruction fields
    assign irOp     = instrOp'(ir[dataWidth-1:addrWidth]);
    assign irAddr   = ir[addrWidth-1:0];
    assign op       = irOp;
    assign jumpAddr = irAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= stIdle;
            ir      <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
        end else begin
            state <= nextState;
            // fetched word is on the memory output during decode
            if (state == stDecode) begin
                ir <= memRData;
            end
            if (state == stIdle && start) begin
                running <= 1'b1;
                halted  <= 1'b0;
            end else if (state == stOperand && irOp == opHalt) begin
                running <= 1'b0;
                halted  <= 1'b1;
            end
        end
    end

    always_comb begin
        nextState  = state;
        cpuEn      = 1'b0;
        cpuWe      = 1'b0;
        cpuAddr    = pc;
        pcClear    = 1'b0;
        pcInc      = 1'b0;
        pcLoad     = 1'b0;
        accWe      = 1'b0;
        accFromMem = 1'b0;
        case (state)
            stIdle: begin
                // pc restarts at word 0 on every start
                if (start) begin
                    pcClear   = 1'b1;
                    nextState = stFetch;
                end
            end
            stFetch: begin
                // instruction read at pc
                cpuEn     = 1'b1;
                nextState = stDecode;
            end
            stDecode: begin
                pcInc     = 1'b1;
                nextState = stOperand;
            end
            stOperand: begin
                cpuAddr   = irAddr;
                nextState = stFetch;
                case (irOp)
                    opStore: begin
                        // accumulator goes out on the CPU write port
                        cpuEn = 1'b1;
                        cpuWe = 1'b1;
                    end
                    opJump: begin
                        pcLoad = 1'b1;
                    end
                    opJumpZero: begin
                        pcLoad = zero;
                    end
                    opHalt: begin
                        nextState = stIdle;
                    end
                    default: begin
                        // operand read for load and ALU ops
                        cpuEn     = 1'b1;
                        nextState = stExecute;
                    end
                endcase
            end
            stExecute: begin
                accWe      = 1'b1;
                accFromMem = (irOp == opLoad);
                nextState  = stFetch;
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

endmodule

// ==== source/executeUnit.sv ====
`timescale 1ns/1ns

module executeUnit
    import cpuPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 accWe,
    input  logic [dataWidth-1:0] aluResult,
    input  logic [dataWidth-1:0] memData,
    input  logic                 accFromMem,
    output logic [dataWidth-1:0] acc,
    output logic                 zero
);

    logic [dataWidth-1:0] accNext;

    // load takes memory directly, all else comes from the ALU
    assign accNext = accFromMem ? memData : aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            acc  <= '0;
            // matches the cleared accumulator
            zero <= 1'b1;
        end else if (accWe) begin
            acc  <= accNext;
            // flag follows the value just written, for jump-if-zero
            zero <= (accNext == '0);
        end
    end

endmodule

// ==== source/mainMemory.sv ====
`timescale 1ns/1ns

module mainMemory
    import cpuPkg::*;
#(
    parameter int memWords = 4096
) (
    input  logic                 clk,
    input  logic                 cpuEn,
    input  logic                 cpuWe,
    input  logic [addrWidth-1:0] cpuAddr,
    input  logic [dataWidth-1:0] cpuWData,
    input  logic                 hostEn,
    input  logic                 hostWe,
    input  logic [addrWidth-1:0] hostAddr,
    input  logic [dataWidth-1:0] hostWData,
    output logic [dataWidth-1:0] rData
);

    // smaller arrays just drop the upper address bits
    localparam int idxWidth = $clog2(memWords);

    logic [dataWidth-1:0] mem [memWords];
    logic [idxWidth-1:0]  cpuIdx;
    logic [idxWidth-1:0]  hostIdx;

    assign cpuIdx  = cpuAddr[idxWidth-1:0];
    assign hostIdx = hostAddr[idxWidth-1:0];

    // one port, CPU first, host only when the CPU is quiet
    always_ff @(posedge clk) begin
        if (cpuEn) begin
            if (cpuWe) begin
                mem[cpuIdx] <= cpuWData;
            end
            // read data valid the cycle after the enable
            rData <= mem[cpuIdx];
        end else if (hostEn) begin
            if (hostWe) begin
                mem[hostIdx] <= hostWData;
            end
            rData <= mem[hostIdx];
        end
    end

endmodule

// ==== source/programCounter.sv ====
`timescale 1ns/1ns

module programCounter
    import cpuPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 pcClear,
    input  logic                 pcInc,
    input  logic                 pcLoad,
    input  logic [addrWidth-1:0] jumpAddr,
    output logic [addrWidth-1:0] pc
);

    // clear beats load, load beats increment
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (pcClear) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= jumpAddr;
        end else if (pcInc) begin
            // top of the address space rolls over to 0
            pc <= pc + 1'b1;
        end
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu
    import cpuPkg::*;
(
    input  instrOp               op,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] result
);

    // a is the accumulator, b the operand read from memory
    always_comb begin
        case (op)
            opAdd: result = a + b;
            opSub: result = a - b;
            // low half of the product only
            opMul: result = a * b;
            // divide by zero saturates to all ones
            opDiv: result = (b == '0) ? '1 : a / b;
            opAnd: result = a & b;
            opOr:  result = a | b;
            opXor: result = a ^ b;
            // single-bit shifts, operand unused
            opShl: result = a << 1;
            opShr: result = a >> 1;
            opRol: result = {a[dataWidth-2:0], a[dataWidth-1]};
            // boolean result as 1 or 0
            opCmpEq: result = {{(dataWidth - 1){1'b0}}, a == b};
            // load and everything else passes the operand
            default: result = b;
        endcase
    end

endmodule

// ==== source/cpuPkg.sv ====
package cpuPkg;

    // word size shared by memory, accumulator and instructions
    localparam int dataWidth = 16;
    // instruction address field, 4096 words at most
    localparam int addrWidth = 12;

    // opcode sits in the top 4 bits of every instruction
    typedef enum logic [3:0] {
        opLoad,
        opStore,
        opAdd,
        opSub,
        opMul,
        opDiv,
        opAnd,
        opOr,
        opXor,
        opShl,
        opShr,
        opRol,
        opCmpEq,
        opJump,
        opJumpZero,
        opHalt
    } instrOp;

    // control sequence, one state per cycle
    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stDecode,
        stOperand,
        stExecute
    } cpuState;

    // AXI response codes
    localparam logic [1:0] axiOkay   = 2'b00;
    localparam logic [1:0] axiSlvErr = 2'b10;

endpackage
